// File: hw/bl_split_fsm.sv
`timescale 1ns/1ns

module bl_split_fsm (
        input  logic                          i_clk,
        input  logic                          i_reset,
        input  decode_front_pkg::pipe_ctrl_t  i_ctrl,
        input  decode_front_pkg::fetch_word_t i_instr,
        input  logic                          i_instr_valid,
        input  decode_front_pkg::irq_t        i_ints,
        output decode_front_pkg::fetch_word_t o_instr,
        output logic                          o_instr_valid,
        output decode_front_pkg::irq_t        o_ints,
        output logic                          o_stall
);

        import decode_front_pkg::*;

        // IDLE passes words, BRANCH emits the second half of a BL.
        typedef enum logic {
                IDLE   = 1'b0,
                BRANCH = 1'b1
        } state_t;

        state_t state_ff, state_nxt;
        logic   is_bl;
        logic   seq_clear;
        logic   seq_hold;

        always_comb
        begin
                // Branch with the link bit set.
                is_bl         = (i_instr.word[27:24] == 4'b1011);

                o_instr       = i_instr;
                o_instr_valid = i_instr_valid;
                o_ints        = i_ints;
                o_stall       = 1'b0;
                state_nxt     = IDLE;

                if (i_instr_valid)
                begin
                        case (state_ff)
                        IDLE:
                        begin
                                if (is_bl)
                                begin
                                        // SUB LR, PC, #4 under the BL condition.
                                        o_instr.word = {i_instr.word[31:28], 2'b00, 1'b1,
                                                        4'b0010, 1'b0, PC_INDEX, LR_INDEX,
                                                        12'd4};
                                        o_stall      = 1'b1;
                                        o_ints       = '0;
                                        state_nxt    = BRANCH;
                                end
                        end
                        BRANCH:
                        begin
                                // Same word again, now a plain branch.
                                o_instr.word[24] = 1'b0;
                                o_ints           = '0;
                        end
                        endcase
                end
        end

        assign seq_clear = i_ctrl.clear_wb | i_ctrl.clear_alu;
        assign seq_hold  = i_ctrl.data_stall | i_ctrl.stall_shifter | i_ctrl.stall_issue;

        always_ff @(posedge i_clk)
        begin
                if (i_reset || seq_clear)
                begin
                        state_ff <= IDLE;
                end
                else if (!seq_hold)
                begin
                        state_ff <= state_nxt;
                end
        end

endmodule

// File: hw/block_xfer_expander.sv
`timescale 1ns/1ns

module block_xfer_expander (
        input  logic                          i_clk,
        input  logic                          i_reset,
        input  decode_front_pkg::pipe_ctrl_t  i_ctrl,
        input  decode_front_pkg::fetch_word_t i_instr,
        input  logic                          i_instr_valid,
        input  decode_front_pkg::irq_t        i_ints,
        output decode_front_pkg::fetch_word_t o_instr,
        output logic                          o_instr_valid,
        output decode_front_pkg::irq_t        o_ints,
        output logic                          o_stall
);

        // Sequence state.
        logic               active_ff, active_nxt;
        logic [15:0]        list_ff, list_nxt;
        logic signed [11:0] offset_ff, offset_nxt;

        // Working values for the current transfer.
        logic               is_block;
        logic               expanding;
        logic [4:0]         reg_count;
        logic signed [11:0] four_n;
        logic signed [11:0] start_offset;
        logic [15:0]        cur_list;
        logic signed [11:0] cur_offset;
        logic [3:0]         cur_reg;
        logic [15:0]        rest_list;
        logic [11:0]        abs_offset;
        logic [31:0]        xfer_word;
        logic               seq_clear;
        logic               seq_hold;

        // Number of registers in a list.
        function automatic logic [4:0] count_ones(input logic [15:0] list);
                logic [4:0] n;
                n = '0;
                for (int i = 0; i < 16; i++)
                begin
                        n = n + {4'd0, list[i]};
                end
                return n;
        endfunction

        // Lowest register in a list, scanned from the top down.
        function automatic logic [3:0] lowest_reg(input logic [15:0] list);
                logic [3:0] r;
                r = '0;
                for (int i = 15; i >= 0; i--)
                begin
                        if (list[i])
                        begin
                                r = 4'(i);
                        end
                end
                return r;
        endfunction

        // Starting offset from the P and U bits.
        always_comb
        begin
                reg_count = count_ones(i_instr.word[15:0]);
                four_n    = $signed({5'd0, reg_count, 2'b00});
                case ({i_instr.word[24], i_instr.word[23]})
                2'b01:   start_offset = 12'sd0;
                2'b11:   start_offset = 12'sd4;
                2'b00:   start_offset = 12'sd4 - four_n;
                default: start_offset = -four_n;
                endcase
        end

        always_comb
        begin
                // LDM/STM with at least one register.
                is_block   = (i_instr.word[27:25] == 3'b100) && (i_instr.word[15:0] != 16'd0);
                expanding  = active_ff || (i_instr_valid && is_block);

                // First transfer reads from the word, later ones from state.
                cur_list   = active_ff ? list_ff : i_instr.word[15:0];
                cur_offset = active_ff ? offset_ff : start_offset;
                cur_reg    = lowest_reg(cur_list);
                rest_list  = cur_list & ~(16'd1 << cur_reg);
                abs_offset = cur_offset[11] ? $unsigned(-cur_offset) : $unsigned(cur_offset);

                // LDR/STR Rd, [Rn, #+/-imm12] with P=1, W=0, B=0.
                xfer_word  = {i_instr.word[31:28], 2'b01, 1'b0, 1'b1, ~cur_offset[11],
                              1'b0, 1'b0, i_instr.word[20], i_instr.word[19:16],
                              cur_reg, abs_offset};

                // Other words pass untouched.
                o_instr       = i_instr;
                o_instr_valid = i_instr_valid;
                o_ints        = i_ints;
                o_stall       = 1'b0;
                active_nxt    = 1'b0;
                list_nxt      = '0;
                offset_nxt    = '0;

                if (expanding)
                begin
                        o_instr.word = xfer_word;
                        // Fetch holds the word until the last register.
                        o_stall      = (rest_list != 16'd0);
                        active_nxt   = (rest_list != 16'd0);
                        list_nxt     = rest_list;
                        offset_nxt   = cur_offset + 12'sd4;
                end

                // No interrupts once the first transfer has left.
                if (active_ff)
                begin
                        o_instr_valid = 1'b1;
                        o_ints        = '0;
                end
        end

        assign seq_clear = i_ctrl.clear_wb | i_ctrl.clear_alu;
        // Any downstream stall freezes the sequence.
        assign seq_hold  = i_ctrl.data_stall | i_ctrl.stall_shifter | i_ctrl.stall_issue;

        always_ff @(posedge i_clk)
        begin
                if (i_reset || seq_clear)
                begin
                        active_ff <= 1'b0;
                end
                else if (!seq_hold)
                begin
                        active_ff <= active_nxt;
                end
        end

        // Remaining list and running offset.
        always_ff @(posedge i_clk)
        begin
                if (!seq_hold)
                begin
                        list_ff   <= list_nxt;
                        offset_ff <= offset_nxt;
                end
        end

endmodule

// File: hw/decode_front_pkg.sv
package decode_front_pkg;

        // Register numbers with a fixed role.
        localparam logic [3:0] LR_INDEX = 4'd14;
        localparam logic [3:0] PC_INDEX = 4'd15;

        // One instruction as delivered by fetch.
        // Ext carries three status bits next to the word.
        typedef struct packed {
                logic [2:0]  ext;
                logic [31:0] word;
        } fetch_word_t;

        // Clear and stall levels.
        // Listed from highest to lowest priority.
        typedef struct packed {
                logic clear_wb;
                logic clear_alu;
                logic data_stall;
                logic stall_shifter;
                logic stall_issue;
        } pipe_ctrl_t;

        // Interrupt levels.
        typedef struct packed {
                logic fiq;
                logic irq;
        } irq_t;

        // Coarse instruction class.
        // Thumb and coprocessor words fall into CLASS_OTHER.
        typedef enum logic [1:0] {
                CLASS_DP     = 2'd0,
                CLASS_MEM    = 2'd1,
                CLASS_BRANCH = 2'd2,
                CLASS_OTHER  = 2'd3
        } instr_class_t;

        // Registered decode result for issue.
        typedef struct packed {
                logic         valid;
                logic [3:0]   cond;
                instr_class_t cls;
                logic [3:0]   opcode;
                logic [3:0]   rd;
                logic [3:0]   rn;
                logic         load;
                logic         link;
                // Branch offset, or imm12 zero-extended.
                logic [23:0]  imm;
                logic [2:0]   ext;
                irq_t         ints;
        } decode_out_t;

endpackage

// File: hw/decode_front_top.sv
`timescale 1ns/1ns

module decode_front_top (
        input  logic                          i_clk,
        input  logic                          i_reset,
        input  decode_front_pkg::pipe_ctrl_t  i_ctrl,
        input  decode_front_pkg::fetch_word_t i_instr,
        input  logic                          i_instr_valid,
        input  decode_front_pkg::irq_t        i_ints,
        output decode_front_pkg::decode_out_t o_decoded,
        output logic                          o_stall_fetch
);

        import decode_front_pkg::*;

        // Expander to splitter.
        fetch_word_t xfer_instr;
        logic        xfer_valid;
        irq_t        xfer_ints;
        logic        xfer_stall;

        // Splitter to decoder.
        fetch_word_t bl_instr;
        logic        bl_valid;
        irq_t        bl_ints;
        logic        bl_stall;

        // LDM/STM expansion.
        block_xfer_expander u_block_xfer_expander (
                .i_clk         (i_clk),
                .i_reset       (i_reset),
                .i_ctrl        (i_ctrl),
                .i_instr       (i_instr),
                .i_instr_valid (i_instr_valid),
                .i_ints        (i_ints),
                .o_instr       (xfer_instr),
                .o_instr_valid (xfer_valid),
                .o_ints        (xfer_ints),
                .o_stall       (xfer_stall)
        );

        // BL split.
        bl_split_fsm u_bl_split_fsm (
                .i_clk         (i_clk),
                .i_reset       (i_reset),
                .i_ctrl        (i_ctrl),
                .i_instr       (xfer_instr),
                .i_instr_valid (xfer_valid),
                .i_ints        (xfer_ints),
                .o_instr       (bl_instr),
                .o_instr_valid (bl_valid),
                .o_ints        (bl_ints),
                .o_stall       (bl_stall)
        );

        // Registered decode.
        instr_decoder u_instr_decoder (
                .i_clk         (i_clk),
                .i_reset       (i_reset),
                .i_ctrl        (i_ctrl),
                .i_instr       (bl_instr),
                .i_instr_valid (bl_valid),
                .i_ints        (bl_ints),
                .o_decoded     (o_decoded)
        );

        // Either sequencer holds fetch.
        assign o_stall_fetch = xfer_stall | bl_stall;

endmodule

// File: hw/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
        input  logic                          i_clk,
        input  logic                          i_reset,
        input  decode_front_pkg::pipe_ctrl_t  i_ctrl,
        input  decode_front_pkg::fetch_word_t i_instr,
        input  logic                          i_instr_valid,
        input  decode_front_pkg::irq_t        i_ints,
        output decode_front_pkg::decode_out_t o_decoded
);

        import decode_front_pkg::*;

        instr_class_t cls;
        decode_out_t  dec_nxt;
        logic         dec_clear;
        logic         dec_hold;

        // Class from the top opcode bits.
        always_comb
        begin
                if (i_instr.word[27:26] == 2'b00)
                begin
                        cls = CLASS_DP;
                end
                else if (i_instr.word[27:26] == 2'b01)
                begin
                        cls = CLASS_MEM;
                end
                else if (i_instr.word[27:25] == 3'b101)
                begin
                        cls = CLASS_BRANCH;
                end
                else
                begin
                        cls = CLASS_OTHER;
                end
        end

        // Field extraction.
        always_comb
        begin
                dec_nxt        = '0;
                dec_nxt.valid  = i_instr_valid;
                dec_nxt.cond   = i_instr.word[31:28];
                dec_nxt.cls    = cls;
                dec_nxt.rd     = i_instr.word[15:12];
                dec_nxt.rn     = i_instr.word[19:16];
                dec_nxt.ext    = i_instr.ext;
                dec_nxt.ints   = i_ints;

                case (cls)
                CLASS_DP:
                begin
                        dec_nxt.opcode = i_instr.word[24:21];
                        dec_nxt.imm    = {12'd0, i_instr.word[11:0]};
                end
                CLASS_MEM:
                begin
                        dec_nxt.load = i_instr.word[20];
                        dec_nxt.imm  = {12'd0, i_instr.word[11:0]};
                end
                CLASS_BRANCH:
                begin
                        // Offset is relative to PC.
                        dec_nxt.link = i_instr.word[24];
                        dec_nxt.rn   = PC_INDEX;
                        // A link branch names LR as its written register.
                        dec_nxt.rd   = i_instr.word[24] ? LR_INDEX : PC_INDEX;
                        dec_nxt.imm  = i_instr.word[23:0];
                end
                default:
                begin
                        // Thumb and coprocessor fields stay raw.
                        dec_nxt.imm = '0;
                end
                endcase
        end

        assign dec_clear = i_ctrl.clear_wb | i_ctrl.clear_alu;
        assign dec_hold  = i_ctrl.data_stall | i_ctrl.stall_shifter | i_ctrl.stall_issue;

        // Valid bit clears on reset and on any clear.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || dec_clear)
                begin
                        o_decoded.valid <= 1'b0;
                end
                else if (!dec_hold)
                begin
                        o_decoded.valid <= dec_nxt.valid;
                end
        end

        // Payload fields.
        always_ff @(posedge i_clk)
        begin
                if (!dec_hold)
                begin
                        o_decoded.cond   <= dec_nxt.cond;
                        o_decoded.cls    <= dec_nxt.cls;
                        o_decoded.opcode <= dec_nxt.opcode;
                        o_decoded.rd     <= dec_nxt.rd;
                        o_decoded.rn     <= dec_nxt.rn;
                        o_decoded.load   <= dec_nxt.load;
                        o_decoded.link   <= dec_nxt.link;
                        o_decoded.imm    <= dec_nxt.imm;
                        o_decoded.ext    <= dec_nxt.ext;
                        o_decoded.ints   <= dec_nxt.ints;
                end
        end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_decode_front \
        -f sim.f \
        -o sim_decode_front

./obj_dir/sim_decode_front > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
        echo "simulation failed"
        exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
        echo "simulation ended without a result"
        exit 1
fi
echo "simulation passed"

// File: sim.f
hw/decode_front_pkg.sv
hw/block_xfer_expander.sv
hw/bl_split_fsm.sv
hw/instr_decoder.sv
hw/decode_front_top.sv
verification/decode_front_properties.sv
verification/tb_decode_front.sv

// File: verification/decode_front_properties.sv
`timescale 1ns/1ns

module decode_front_properties (
        input logic                         i_clk,
        input logic                         i_reset,
        input decode_front_pkg::pipe_ctrl_t i_ctrl,
        input logic                         i_instr_valid,
        input logic                         i_busy,
        input logic                         o_stall,
        input decode_front_pkg::irq_t       o_ints
);

        logic seq_clear;
        logic seq_hold;

        assign seq_clear = i_ctrl.clear_wb | i_ctrl.clear_alu;
        assign seq_hold  = i_ctrl.data_stall | i_ctrl.stall_shifter | i_ctrl.stall_issue;

        // The word after an advancing stall carries no interrupts.
        masked_after_stall: assert property (@(posedge i_clk) disable iff (i_reset)
                (o_stall && !seq_hold && !seq_clear) |=> (o_ints == '0))
                else $error("interrupts forwarded on the word after a stall");

        // A stall raised from idle always enters a sequence.
        stall_enters_sequence: assert property (@(posedge i_clk) disable iff (i_reset)
                (!i_busy && o_stall && !seq_hold && !seq_clear) |=> i_busy)
                else $error("stall raised without entering a sequence");

        // Stall drops on the last word, then back to idle.
        sequence_ends: assert property (@(posedge i_clk) disable iff (i_reset)
                (i_busy && !o_stall && !seq_hold) |=> !i_busy)
                else $error("sequencer stayed busy after its last word");

        // Quiet after reset.
        quiet_after_reset: assert property (@(posedge i_clk)
                ($past(i_reset) && !i_instr_valid) |-> (!o_stall && !i_busy))
                else $error("stall or busy state high after reset");

endmodule

bind block_xfer_expander decode_front_properties u_expander_props (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_ctrl        (i_ctrl),
        .i_instr_valid (i_instr_valid),
        .i_busy        (active_ff),
        .o_stall       (o_stall),
        .o_ints        (o_ints)
);

bind bl_split_fsm decode_front_properties u_splitter_props (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_ctrl        (i_ctrl),
        .i_instr_valid (i_instr_valid),
        .i_busy        (state_ff),
        .o_stall       (o_stall),
        .o_ints        (o_ints)
);

// File: verification/tb_decode_front.sv
`timescale 1ns/1ns

module tb_decode_front;

        import decode_front_pkg::*;

        // One stimulus row.
        typedef struct {
                string       name;
                logic [31:0] word;
                logic [2:0]  ext;
                irq_t        ints;
                pipe_ctrl_t  ctrl;
                int          len;
        } entry_t;

        logic        i_clk;
        logic        i_reset;
        pipe_ctrl_t  i_ctrl;
        fetch_word_t i_instr;
        logic        i_instr_valid;
        irq_t        i_ints;
        decode_out_t o_decoded;
        logic        o_stall_fetch;

        entry_t      stim_q[$];
        decode_out_t exp_q[$];
        logic [31:0] lfsr_state = 32'hefcc;

        decode_front_top DUT (
                .i_clk         (i_clk),
                .i_reset       (i_reset),
                .i_ctrl        (i_ctrl),
                .i_instr       (i_instr),
                .i_instr_valid (i_instr_valid),
                .i_ints        (i_ints),
                .o_decoded     (o_decoded),
                .o_stall_fetch (o_stall_fetch)
        );

        initial
        begin
                i_clk = 1'b0;
                forever
                begin
                        #20 i_clk = ~i_clk;
                end
        end

        // Galois LFSR stepped once per bit taken.
        function automatic logic [31:0] take_bits(input int n);
                logic [31:0] v;
                v = '0;
                for (int i = 0; i < n; i++)
                begin
                        v = {v[30:0], lfsr_state[0]};
                        lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
                end
                return v;
        endfunction

        function automatic void add_entry(input string name, input logic [31:0] word,
                                          input logic [2:0] ext, input logic [1:0] ints,
                                          input logic [4:0] ctrl, input int len);
                entry_t e;
                e.name = name;
                e.word = word;
                e.ext  = ext;
                e.ints = ints;
                e.ctrl = ctrl;
                e.len  = len;
                stim_q.push_back(e);
        endfunction

        // Expected decode results from the instruction format.
        function automatic void build_expected(input entry_t e);
                decode_out_t d;
                int          n;
                int          off;
                int          k;
                exp_q.delete();
                d       = '0;
                d.valid = 1'b1;
                d.cond  = e.word[31:28];
                d.ext   = e.ext;
                if (e.word[27:25] == 3'b100 && e.word[15:0] != 16'd0)
                begin
                        n = $countones(e.word[15:0]);
                        // Start offset by addressing mode IA, IB, DA, DB.
                        case (e.word[24:23])
                        2'b01:   off = 0;
                        2'b11:   off = 4;
                        2'b00:   off = -4 * (n - 1);
                        default: off = -4 * n;
                        endcase
                        k = 0;
                        for (int r = 0; r < 16; r++)
                        begin
                                if (e.word[r])
                                begin
                                        d.cls  = CLASS_MEM;
                                        d.rd   = 4'(r);
                                        d.rn   = e.word[19:16];
                                        d.load = e.word[20];
                                        d.imm  = 24'((off < 0) ? -off : off);
                                        d.ints = (k == 0) ? e.ints : 2'b00;
                                        exp_q.push_back(d);
                                        off = off + 4;
                                        k++;
                                end
                        end
                end
                else if (e.word[27:24] == 4'b1011)
                begin
                        // Link write, then the plain branch.
                        d.cls    = CLASS_DP;
                        d.opcode = 4'b0010;
                        d.rd     = 4'd14;
                        d.rn     = 4'd15;
                        d.imm    = 24'd4;
                        exp_q.push_back(d);
                        d        = '0;
                        d.valid  = 1'b1;
                        d.cond   = e.word[31:28];
                        d.ext    = e.ext;
                        d.cls    = CLASS_BRANCH;
                        d.rd     = 4'd15;
                        d.rn     = 4'd15;
                        d.imm    = e.word[23:0];
                        exp_q.push_back(d);
                end
                else
                begin
                        d.ints = e.ints;
                        d.rd   = e.word[15:12];
                        d.rn   = e.word[19:16];
                        if (e.word[27:26] == 2'b00)
                        begin
                                d.cls    = CLASS_DP;
                                d.opcode = e.word[24:21];
                                d.imm    = {12'd0, e.word[11:0]};
                        end
                        else if (e.word[27:26] == 2'b01)
                        begin
                                d.cls  = CLASS_MEM;
                                d.load = e.word[20];
                                d.imm  = {12'd0, e.word[11:0]};
                        end
                        else if (e.word[27:25] == 3'b101)
                        begin
                                d.cls = CLASS_BRANCH;
                                d.rd  = 4'd15;
                                d.rn  = 4'd15;
                                d.imm = e.word[23:0];
                        end
                        else
                        begin
                                d.cls = CLASS_OTHER;
                        end
                        exp_q.push_back(d);
                end
        endfunction

        task automatic compare(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
                assert (actual === expected)
                else
                begin
                        $display("mismatch %s expected %h actual %h", what, expected, actual);
                        $display("Done: errors found");
                        $fatal(1, "stopped at first error");
                end
        endtask

        // Presents one row; fetch repeats the word while stalled.
        task automatic run_entry(input entry_t e);
                int   step;
                int   hold_left;
                int   cycles;
                logic is_clear;
                logic ctl_on;
                logic stall_seen;
                logic done;
                build_expected(e);
                is_clear  = e.ctrl.clear_wb | e.ctrl.clear_alu;
                hold_left = is_clear ? 1 : 3;
                step      = 0;
                cycles    = 0;
                done      = 1'b0;
                while (!done)
                begin
                        @(negedge i_clk);
                        ctl_on        = (step == 1) && (hold_left > 0) && (e.ctrl != '0);
                        i_instr       = {e.ext, e.word};
                        i_instr_valid = 1'b1;
                        i_ints        = e.ints;
                        i_ctrl        = ctl_on ? e.ctrl : '0;
                        #1 stall_seen = o_stall_fetch;
                        @(posedge i_clk);
                        #1;
                        if (ctl_on && is_clear)
                        begin
                                // Flushed word lets fetch move on.
                                compare($sformatf("%s clear valid", e.name), 64'(1'b0),
                                        64'(o_decoded.valid));
                                step++;
                                done = 1'b1;
                        end
                        else if (ctl_on)
                        begin
                                compare($sformatf("%s held", e.name), 64'(exp_q[0]),
                                        64'(o_decoded));
                                hold_left--;
                        end
                        else
                        begin
                                compare($sformatf("%s step %0d", e.name, step),
                                        64'(exp_q[step]), 64'(o_decoded));
                                compare($sformatf("%s stall %0d", e.name, step),
                                        64'(step + 1 < exp_q.size()), 64'(stall_seen));
                                step++;
                                done = !stall_seen;
                        end
                        cycles++;
                        assert (cycles < 40)
                        else
                        begin
                                $display("timeout: fetch stall never released in %s", e.name);
                                $display("Done: errors found");
                                $fatal(1, "timeout");
                        end
                end
                compare($sformatf("%s length", e.name), 64'(e.len), 64'(step));
        endtask

        initial
        begin
                int          cycles;
                logic [31:0] rnd_word;
                logic [31:0] rnd_ext;
                logic [31:0] rnd_ints;
                i_reset       = 1'b1;
                i_ctrl        = '0;
                i_instr       = '0;
                i_instr_valid = 1'b0;
                i_ints        = '0;

                // Plain words, then sequences.
                add_entry("dp_add", 32'hE281_3025, 3'd1, 2'b01, 5'b00000, 1);
                add_entry("branch", 32'hEA00_0010, 3'd2, 2'b10, 5'b00000, 1);
                add_entry("coproc", 32'hEE01_0F10, 3'd3, 2'b11, 5'b00000, 1);
                add_entry("bl", 32'h1B00_0123, 3'd4, 2'b11, 5'b00000, 2);
                add_entry("ldm_ia", 32'hE894_0025, 3'd5, 2'b01, 5'b00000, 3);
                add_entry("stm_ib", 32'hE98D_8003, 3'd6, 2'b10, 5'b00000, 3);
                add_entry("ldm_da", 32'hE812_00F0, 3'd7, 2'b11, 5'b00000, 4);
                add_entry("stm_db", 32'hE92D_4010, 3'd0, 2'b01, 5'b00000, 2);
                add_entry("ldm_one", 32'hE891_0100, 3'd1, 2'b11, 5'b00000, 1);
                // Clears mid sequence.
                add_entry("ldm_clear_alu", 32'hE894_0025, 3'd2, 2'b01, 5'b01000, 2);
                add_entry("dp_after_clear", 32'hE3A0_1007, 3'd3, 2'b10, 5'b00000, 1);
                add_entry("bl_clear_wb", 32'h0B00_0040, 3'd4, 2'b01, 5'b10000, 2);
                add_entry("b_after_clear", 32'hEAFF_FFFE, 3'd5, 2'b10, 5'b00000, 1);
                // Downstream stalls.
                add_entry("stm_db_issue", 32'hE92D_4010, 3'd6, 2'b11, 5'b00001, 2);
                add_entry("ldm_da_data", 32'hE812_00F0, 3'd7, 2'b10, 5'b00100, 4);
                add_entry("bl_shifter", 32'hEB00_0200, 3'd1, 2'b01, 5'b00010, 2);
                for (int i = 0; i < 6; i++)
                begin
                        rnd_word = take_bits(26);
                        rnd_ext  = take_bits(3);
                        rnd_ints = take_bits(2);
                        add_entry($sformatf("random_dp_%0d", i),
                                  {4'hE, 2'b00, rnd_word[25:0]}, rnd_ext[2:0],
                                  rnd_ints[1:0], 5'b00000, 1);
                end

                cycles = 0;
                while (cycles < 16)
                begin
                        @(posedge i_clk);
                        cycles++;
                end
                @(negedge i_clk);
                i_reset = 1'b0;
                #1;
                compare("reset stall", 64'd0, 64'(o_stall_fetch));
                compare("reset valid", 64'd0, 64'(o_decoded.valid));

                foreach (stim_q[i])
                begin
                        run_entry(stim_q[i]);
                end

                // Bubble decodes as invalid.
                @(negedge i_clk);
                i_instr_valid = 1'b0;
                @(posedge i_clk);
                #1;
                compare("bubble valid", 64'd0, 64'(o_decoded.valid));

                $display("Done: no errors");
                $finish;
        end

endmodule
